// ==== compile.f ====
+incdir+include
hdl/vliwPkg.sv
hdl/instrCache.sv
hdl/programCounter.sv
hdl/runSequencer.sv
hdl/bundleDecoder.sv
hdl/regFile.sv
hdl/arithUnit.sv
hdl/vliwCore.sv
tb/tbCore.sv

// ==== Bender.yml ====
package:
  name: vliwCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/vliwPkg.sv
      - hdl/instrCache.sv
      - hdl/programCounter.sv
      - hdl/runSequencer.sv
      - hdl/bundleDecoder.sv
      - hdl/regFile.sv
      - hdl/arithUnit.sv
      - hdl/vliwCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tbCore.sv

// ==== tb/tbCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module tbCore;

	localparam int numTests = 8;
	localparam int maxBundles = 60;
	localparam int bundlesPerLine = `VLIW_LINE_W / `VLIW_BUNDLE_W;

	// program generator modes
	localparam int modeImm = 0;
	localparam int modeReg = 1;
	localparam int modeFlags = 2;
	localparam int modeNop = 3;
	localparam int modeMixed = 4;

	// both lanes of one bundle retire together
	typedef struct packed {
		vliwPkg::writeback_t a;
		vliwPkg::writeback_t b;
	} bundleWb_t;

	logic clock;
	logic reset;
	vliwPkg::icacheWrite_t icacheWrite;
	logic start;
	logic [15:0] pc;
	vliwPkg::writeback_t wbA;
	vliwPkg::writeback_t wbB;
	logic running;
	logic done;

	logic [`VLIW_BUNDLE_W-1:0] prog [maxBundles + 2];
	logic [`VLIW_DATA_W-1:0] modelRegs [32];
	bundleWb_t expected [$];
	bundleWb_t nextWb;
	int lengths [numTests];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	vliwCore DUT (
		.clock_i(clock), .reset_i(reset), .icacheWrite_i(icacheWrite), .start_i(start),
		.pc_o(pc), .wbA_o(wbA), .wbB_o(wbB), .running_o(running), .done_o(done)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Errors found");
			$finish;
		end
	end

	task automatic reportValue(string name, logic [63:0] expValue, logic [63:0] actValue);
		errorCount++;
		$display("ERR t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expValue, actValue);
	endtask

	task automatic reportFailure(string what);
		errorCount++;
		$display("t=%0t %s", $time, what);
	endtask

	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	// writebacks sampled mid-cycle
	always @(negedge clock)
	begin
		if (!reset && (wbA.valid || wbB.valid))
		begin
			checkCount++;
			if (expected.size() == 0)
				reportFailure("writeback seen with no bundle left to retire");
			else
			begin
				nextWb = expected.pop_front();
				if (wbA.valid !== nextWb.a.valid || (nextWb.a.valid && wbA !== nextWb.a))
					reportValue("wbA_o", nextWb.a, wbA);
				if (wbB.valid !== nextWb.b.valid || (nextWb.b.valid && wbB !== nextWb.b))
					reportValue("wbB_o", nextWb.b, wbB);
			end
		end
	end

	//////////////////////////////////////////////////
	// architectural model
	//////////////////////////////////////////////////
	function automatic vliwPkg::writeback_t modelLane(vliwPkg::instr_t ins);
		vliwPkg::writeback_t wb;
		logic [15:0] lhs;
		logic [15:0] rhs;
		wb = '0;
		lhs = modelRegs[ins.dest];
		rhs = ins.format ? ins.operand : modelRegs[ins.operand[4:0]];
		wb.valid = 1'b1;
		wb.addr = ins.dest;
		case (ins.opcode)
			vliwPkg::ADD:
			begin
				wb.data = lhs + rhs;
				// carry when the true sum leaves 16 bits
				wb.overflow = (int'(lhs) + int'(rhs)) > 65535;
			end
			vliwPkg::SUB:
			begin
				wb.data = lhs - rhs;
				wb.underflow = rhs > lhs;
			end
			vliwPkg::AND: wb.data = lhs & rhs;
			vliwPkg::OR: wb.data = lhs | rhs;
			vliwPkg::XOR: wb.data = lhs ^ rhs;
			vliwPkg::SHL: wb.data = lhs << rhs[3:0];
			vliwPkg::SHR: wb.data = lhs >> rhs[3:0];
			vliwPkg::MOV: wb.data = rhs;
			default: wb = '0;
		endcase
		return wb;
	endfunction

	function automatic int unsigned pick(int unsigned lo, int unsigned hi);
		return lo + ($urandom % (hi - lo + 1));
	endfunction

	function automatic vliwPkg::opcode_e pickOpcode(int mode);
		int unsigned roll;
		roll = pick(0, 9);
		if (mode == modeFlags && roll < 7)
			return vliwPkg::opcode_e'(7'(pick(1, 2)));
		if (mode == modeNop && roll < 2)
			return vliwPkg::NOP;
		// unknown opcodes sit between MOV and HALT
		if (mode == modeNop && roll < 4)
			return vliwPkg::opcode_e'(7'(pick(9, 126)));
		if (mode == modeMixed && roll == 0)
			return vliwPkg::NOP;
		return vliwPkg::opcode_e'(7'(pick(1, 8)));
	endfunction

	// busy holds the dests of the two previous bundles
	function automatic vliwPkg::instr_t makeInstr(int mode, logic [31:0] busy,
		int avoidDest, int preferSrc);
		vliwPkg::instr_t ins;
		int dest;
		int src;
		ins = '0;
		ins.opcode = pickOpcode(mode);
		if (mode == modeImm)
			ins.format = 1'b1;
		else if (mode == modeReg)
			ins.format = 1'b0;
		else
			ins.format = 1'($urandom % 2);
		do
			dest = pick(0, 31);
		while (busy[dest] || dest == avoidDest);
		ins.dest = 5'(dest);
		if (ins.format)
			ins.operand = 16'($urandom);
		else
		begin
			src = preferSrc;
			while (src < 0 || busy[src])
				src = pick(0, 31);
			ins.operand = 16'(src);
		end
		return ins;
	endfunction

	task automatic buildProgram(int mode, int n, int haltLane);
		vliwPkg::instr_t insA;
		vliwPkg::instr_t insB;
		bundleWb_t wbs;
		logic [31:0] recent1;
		logic [31:0] recent2;
		int destA [maxBundles];
		int prefer;
		recent1 = '0;
		recent2 = '0;
		for (int k = 0; k < n; k++)
		begin
			// read three bundles after the write, the nearest legal distance
			prefer = (mode == modeReg && k >= 3) ? destA[k - 3] : -1;
			insA = makeInstr(mode, recent1 | recent2, -1, prefer);
			insB = makeInstr(mode, recent1 | recent2, insA.dest, -1);
			if (k == n - 1 && haltLane == 0)
				insA.opcode = vliwPkg::HALT;
			if (k == n - 1 && haltLane == 1)
				insB.opcode = vliwPkg::HALT;
			destA[k] = insA.dest;
			prog[k] = {insB, insA};
			wbs.a = modelLane(insA);
			wbs.b = modelLane(insB);
			recent2 = recent1;
			recent1 = '0;
			if (wbs.a.valid)
			begin
				modelRegs[wbs.a.addr] = wbs.a.data;
				recent1[wbs.a.addr] = 1'b1;
			end
			if (wbs.b.valid)
			begin
				modelRegs[wbs.b.addr] = wbs.b.data;
				recent1[wbs.b.addr] = 1'b1;
			end
			if (wbs.a.valid || wbs.b.valid)
				expected.push_back(wbs);
		end
		// writing bundles behind the HALT that squash must drop
		for (int k = n; k < n + 2; k++)
			prog[k] = {makeInstr(modeImm, '0, -1, -1), makeInstr(modeImm, '0, -1, -1)};
	endtask

	//////////////////////////////////////////////////
	// program load and run control
	//////////////////////////////////////////////////
	task automatic loadProgram(int n);
		logic [`VLIW_LINE_W-1:0] line;
		int lineCount;
		lineCount = (n + bundlesPerLine - 1) / bundlesPerLine;
		for (int l = 0; l < lineCount; l++)
		begin
			line = '0;
			for (int s = 0; s < bundlesPerLine; s++)
				if (l * bundlesPerLine + s < n)
					line[s * `VLIW_BUNDLE_W +: `VLIW_BUNDLE_W] = prog[l * bundlesPerLine + s];
			icacheWrite.enable = 1'b1;
			icacheWrite.lineAddr = 8'(l);
			icacheWrite.line = line;
			nextCycle();
		end
		icacheWrite.enable = 1'b0;
	endtask

	task automatic finishRun(int n);
		logic [15:0] expPc;
		// HALT bundle plus the two fetches behind it
		expPc = 16'((n + 2) * `VLIW_BUNDLE_BYTES);
		while (!done)
			nextCycle();
		checkCount += 3;
		if (expected.size() != 0)
			reportFailure($sformatf("done_o rose with %0d bundles not retired", expected.size()));
		if (running !== 1'b0)
			reportValue("running_o", 0, running);
		if (pc !== expPc)
			reportValue("pc_o", expPc, pc);
		repeat (4) nextCycle();
		checkCount += 2;
		if (pc !== expPc)
			reportValue("pc_o", expPc, pc);
		if (done !== 1'b1)
			reportValue("done_o", 1, done);
	endtask

	task automatic resetMidRun(int waitCycles);
		repeat (waitCycles) nextCycle();
		reset = 1'b1;
		repeat (2) nextCycle();
		checkCount += 4;
		if (running !== 1'b0)
			reportValue("running_o", 0, running);
		if (done !== 1'b0)
			reportValue("done_o", 0, done);
		if (wbA.valid !== 1'b0)
			reportValue("wbA_o.valid", 0, wbA.valid);
		if (wbB.valid !== 1'b0)
			reportValue("wbB_o.valid", 0, wbB.valid);
		// everything in flight is lost
		expected.delete();
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		reset = 1'b0;
		nextCycle();
	endtask

	task automatic runTest(int t, string name, int mode, int haltLane, bit resetMid);
		int n;
		int errorsBefore;
		n = lengths[t];
		errorsBefore = errorCount;
		buildProgram(mode, n, haltLane);
		loadProgram(n + 2);
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		// run begins with the PC cleared
		checkCount += 2;
		if (running !== 1'b1)
			reportValue("running_o", 1, running);
		if (pc !== 16'd0)
			reportValue("pc_o", 0, pc);
		if (resetMid)
			resetMidRun(pick(4, n));
		else
			finishRun(n);
		$display("test %0d %s: %0d bundles, %0d errors", t, name, n,
			errorCount - errorsBefore);
	endtask

	initial
	begin
		void'($urandom(63645));
		reset = 1'b1;
		start = 1'b0;
		icacheWrite = '0;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		for (int t = 0; t < numTests; t++)
		begin
			lengths[t] = pick(20, maxBundles);
			cycleLimit += (lengths[t] + 10) * 2;
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		runTest(0, "register-immediate", modeImm, 0, 1'b0);
		runTest(1, "register-register", modeReg, pick(0, 1), 1'b0);
		runTest(2, "status flags", modeFlags, pick(0, 1), 1'b0);
		runTest(3, "nop and unknown opcodes", modeNop, pick(0, 1), 1'b0);
		runTest(4, "halt in lane B", modeMixed, 1, 1'b0);
		runTest(5, "back-to-back run", modeMixed, pick(0, 1), 1'b0);
		runTest(6, "reset mid-run", modeMixed, pick(0, 1), 1'b1);
		runTest(7, "run after reset", modeMixed, 0, 1'b0);
		$display("tests %0d, checks %0d, errors %0d", numTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/vliwCore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module vliwCore (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire vliwPkg::icacheWrite_t icacheWrite_i,
	input  wire logic start_i,
	output logic [15:0] pc_o,
	output vliwPkg::writeback_t wbA_o,
	output vliwPkg::writeback_t wbB_o,
	output logic running_o,
	output logic done_o
);

	logic clear;
	logic advance;
	logic squash;
	logic haltSeen;
	logic [`VLIW_BUNDLE_W-1:0] bundle;
	logic bundleValid;
	vliwPkg::laneOp_t laneA;
	vliwPkg::laneOp_t laneB;
	vliwPkg::execOp_t execA;
	vliwPkg::execOp_t execB;

	//////////////////////////////////////////////////
	// control and fetch
	//////////////////////////////////////////////////
	runSequencer sequencer (
		.clock_i(clock_i), .reset_i(reset_i), .start_i(start_i), .haltSeen_i(haltSeen),
		.clear_o(clear), .advance_o(advance), .squash_o(squash),
		.running_o(running_o), .done_o(done_o)
	);

	programCounter pc (
		.clock_i(clock_i), .reset_i(reset_i), .clear_i(clear), .advance_i(advance),
		.bundleAddr_o(pc_o)
	);

	// a bundle is fetched whenever the PC advances
	instrCache icache (
		.clock_i(clock_i), .reset_i(reset_i), .write_i(icacheWrite_i),
		.bundleAddr_i(pc_o), .fetchValid_i(advance), .squash_i(squash),
		.bundle_o(bundle), .bundleValid_o(bundleValid)
	);

	//////////////////////////////////////////////////
	// decode, operand read, execute
	//////////////////////////////////////////////////
	bundleDecoder decoder (
		.clock_i(clock_i), .reset_i(reset_i), .bundle_i(bundle),
		.bundleValid_i(bundleValid), .squash_i(squash),
		.laneA_o(laneA), .laneB_o(laneB), .haltSeen_o(haltSeen)
	);

	regFile registers (
		.clock_i(clock_i), .reset_i(reset_i), .laneA_i(laneA), .laneB_i(laneB),
		.wbA_i(wbA_o), .wbB_i(wbB_o), .execA_o(execA), .execB_o(execB)
	);

	arithUnit aluA (
		.clock_i(clock_i), .reset_i(reset_i), .op_i(execA), .wb_o(wbA_o)
	);

	arithUnit aluB (
		.clock_i(clock_i), .reset_i(reset_i), .op_i(execB), .wb_o(wbB_o)
	);

endmodule

`default_nettype wire

// ==== hdl/arithUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module arithUnit (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire vliwPkg::execOp_t op_i,
	output vliwPkg::writeback_t wb_o
);

	logic [`VLIW_DATA_W:0] wide;
	logic [`VLIW_DATA_W-1:0] result;
	logic overflow;
	logic underflow;

	// dest op source, flags only from ADD and SUB
	always_comb
	begin
		wide = '0;
		result = '0;
		overflow = 1'b0;
		underflow = 1'b0;
		case (op_i.opcode)
			vliwPkg::ADD:
			begin
				wide = {1'b0, op_i.primary} + {1'b0, op_i.secondary};
				result = wide[`VLIW_DATA_W-1:0];
				overflow = wide[`VLIW_DATA_W];
			end
			vliwPkg::SUB:
			begin
				// borrow shows in the extra bit
				wide = {1'b0, op_i.primary} - {1'b0, op_i.secondary};
				result = wide[`VLIW_DATA_W-1:0];
				underflow = wide[`VLIW_DATA_W];
			end
			vliwPkg::AND: result = op_i.primary & op_i.secondary;
			vliwPkg::OR:  result = op_i.primary | op_i.secondary;
			vliwPkg::XOR: result = op_i.primary ^ op_i.secondary;
			vliwPkg::SHL: result = op_i.primary << op_i.secondary[3:0];
			vliwPkg::SHR: result = op_i.primary >> op_i.secondary[3:0];
			vliwPkg::MOV: result = op_i.secondary;
			default:      result = '0;
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			wb_o.valid <= 1'b0;
		else
			wb_o <= '{valid: op_i.valid, addr: op_i.dest, data: result,
				overflow: overflow, underflow: underflow};
	end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module regFile (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire vliwPkg::laneOp_t laneA_i,
	input  wire vliwPkg::laneOp_t laneB_i,
	input  wire vliwPkg::writeback_t wbA_i,
	input  wire vliwPkg::writeback_t wbB_i,
	output vliwPkg::execOp_t execA_o,
	output vliwPkg::execOp_t execB_o
);

	localparam int regCount = 2 ** `VLIW_REG_ADDR_W;

	logic [`VLIW_DATA_W-1:0] regs [regCount];

	// write-first, lanes never share a destination
	function automatic logic [`VLIW_DATA_W-1:0] readReg(logic [`VLIW_REG_ADDR_W-1:0] addr);
		if (wbA_i.valid && wbA_i.addr == addr)
			return wbA_i.data;
		if (wbB_i.valid && wbB_i.addr == addr)
			return wbB_i.data;
		return regs[addr];
	endfunction

	function automatic vliwPkg::execOp_t readLane(vliwPkg::laneOp_t lane);
		vliwPkg::execOp_t op;
		op.valid = lane.valid;
		op.opcode = lane.opcode;
		op.dest = lane.dest;
		op.primary = readReg(lane.dest);
		op.secondary = lane.format ? lane.operand
			: readReg(lane.operand[`VLIW_REG_ADDR_W-1:0]);
		return op;
	endfunction

	//////////////////////////////////////////////////
	// two write ports
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wbA_i.valid)
				regs[wbA_i.addr] <= wbA_i.data;
			if (wbB_i.valid)
				regs[wbB_i.addr] <= wbB_i.data;
		end
	end

	// operand read stage
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			execA_o.valid <= 1'b0;
			execB_o.valid <= 1'b0;
		end
		else
		begin
			execA_o <= readLane(laneA_i);
			execB_o <= readLane(laneB_i);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/bundleDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module bundleDecoder (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire logic [`VLIW_BUNDLE_W-1:0] bundle_i,
	input  wire logic bundleValid_i,
	input  wire logic squash_i,
	output vliwPkg::laneOp_t laneA_o,
	output vliwPkg::laneOp_t laneB_o,
	output logic haltSeen_o
);

	vliwPkg::instr_t instrA;
	vliwPkg::instr_t instrB;
	logic live;

	// only opcodes that produce a result
	function automatic logic writesBack(vliwPkg::opcode_e opcode);
		case (opcode)
			vliwPkg::ADD, vliwPkg::SUB, vliwPkg::AND, vliwPkg::OR,
			vliwPkg::XOR, vliwPkg::SHL, vliwPkg::SHR, vliwPkg::MOV:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic vliwPkg::laneOp_t decodeLane(vliwPkg::instr_t instr, logic isLive);
		vliwPkg::laneOp_t op;
		op.valid = isLive && writesBack(instr.opcode);
		op.opcode = instr.opcode;
		op.format = instr.format;
		op.dest = instr.dest;
		op.operand = instr.operand;
		return op;
	endfunction

	// lane A low half, lane B high half
	assign instrA = bundle_i[`VLIW_INSTR_W-1:0];
	assign instrB = bundle_i[`VLIW_BUNDLE_W-1:`VLIW_INSTR_W];
	assign live = bundleValid_i && !squash_i;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			laneA_o.valid <= 1'b0;
			laneB_o.valid <= 1'b0;
			haltSeen_o <= 1'b0;
		end
		else
		begin
			laneA_o <= decodeLane(instrA, live);
			laneB_o <= decodeLane(instrB, live);
			haltSeen_o <= live && (instrA.opcode == vliwPkg::HALT
				|| instrB.opcode == vliwPkg::HALT);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/runSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module runSequencer (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire logic start_i,
	input  wire logic haltSeen_i,
	output logic clear_o,
	output logic advance_o,
	output logic squash_o,
	output logic running_o,
	output logic done_o
);

	localparam int drainW = $clog2(`VLIW_DRAIN_CYCLES + 1);
	localparam logic [drainW-1:0] drainLast = drainW'(`VLIW_DRAIN_CYCLES - 1);

	typedef enum logic [1:0] {
		stIdle,
		stRun,
		stDrain,
		stDone
	} state_e;

	state_e state;
	logic [drainW-1:0] drainCount;
	logic startAccept;

	// start only from idle or after a finished run
	assign startAccept = start_i && (state == stIdle || state == stDone);

	assign clear_o = startAccept;
	assign advance_o = (state == stRun) && !haltSeen_i;
	assign squash_o = (state == stRun) && haltSeen_i;
	assign running_o = (state == stRun) || (state == stDrain);
	assign done_o = (state == stDone);

	//////////////////////////////////////////////////
	// state machine and drain timer
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			state <= stIdle;
			drainCount <= '0;
		end
		else
		begin
			case (state)
				stIdle, stDone:
					if (startAccept)
						state <= stRun;
				stRun:
					if (haltSeen_i)
					begin
						state <= stDrain;
						drainCount <= '0;
					end
				stDrain:
				begin
					// last writeback lands as the count expires
					drainCount <= drainCount + 1'b1;
					if (drainCount == drainLast)
						state <= stDone;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module programCounter (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire logic clear_i,
	input  wire logic advance_i,
	output logic [15:0] bundleAddr_o
);

	localparam logic [15:0] step = 16'(`VLIW_BUNDLE_BYTES);

	// byte address of the next bundle
	always_ff @(posedge clock_i)
	begin
		if (reset_i || clear_i)
			bundleAddr_o <= '0;
		else if (advance_i)
			bundleAddr_o <= bundleAddr_o + step;
	end

endmodule

`default_nettype wire

// ==== hdl/instrCache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vliwCore_defs.svh"

module instrCache (
	input  wire logic clock_i,
	input  wire logic reset_i,
	input  wire vliwPkg::icacheWrite_t write_i,
	input  wire logic [15:0] bundleAddr_i,
	input  wire logic fetchValid_i,
	input  wire logic squash_i,
	output logic [`VLIW_BUNDLE_W-1:0] bundle_o,
	output logic bundleValid_o
);

	localparam int offsetW = $clog2(`VLIW_BUNDLE_BYTES);
	localparam int selW = $clog2(`VLIW_LINE_W / `VLIW_BUNDLE_W);
	localparam int lineIdxW = $clog2(`VLIW_CACHE_LINES);

	logic [`VLIW_LINE_W-1:0] lines [`VLIW_CACHE_LINES];
	logic [`VLIW_LINE_W-1:0] lineReg;
	logic [selW-1:0] selReg;
	logic lineValid;

	// program port, one line per cycle
	always_ff @(posedge clock_i)
	begin
		if (write_i.enable)
			lines[write_i.lineAddr] <= write_i.line;
	end

	//////////////////////////////////////////////////
	// stage 1 line read, stage 2 bundle select
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i)
	begin
		lineReg <= lines[bundleAddr_i[offsetW+selW +: lineIdxW]];
		selReg <= bundleAddr_i[offsetW +: selW];
		bundle_o <= lineReg[selReg*`VLIW_BUNDLE_W +: `VLIW_BUNDLE_W];
		if (reset_i)
		begin
			lineValid <= 1'b0;
			bundleValid_o <= 1'b0;
		end
		else
		begin
			lineValid <= fetchValid_i && !squash_i;
			bundleValid_o <= lineValid && !squash_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/vliwPkg.sv ====
`default_nettype none

`include "vliwCore_defs.svh"

package vliwPkg;

	// values outside this list decode as NOP
	typedef enum logic [6:0] {
		NOP  = 7'd0,
		ADD  = 7'd1,
		SUB  = 7'd2,
		AND  = 7'd3,
		OR   = 7'd4,
		XOR  = 7'd5,
		SHL  = 7'd6,
		SHR  = 7'd7,
		MOV  = 7'd8,
		HALT = 7'd127
	} opcode_e;

	// instruction word as stored in the cache
	typedef struct packed {
		opcode_e opcode;
		logic format;
		logic [`VLIW_REG_ADDR_W-1:0] dest;
		logic [2:0] spare;
		logic [`VLIW_DATA_W-1:0] operand;
	} instr_t;

	// format 1 means operand is an immediate
	typedef struct packed {
		logic valid;
		opcode_e opcode;
		logic format;
		logic [`VLIW_REG_ADDR_W-1:0] dest;
		logic [`VLIW_DATA_W-1:0] operand;
	} laneOp_t;

	typedef struct packed {
		logic valid;
		opcode_e opcode;
		logic [`VLIW_REG_ADDR_W-1:0] dest;
		logic [`VLIW_DATA_W-1:0] primary;
		logic [`VLIW_DATA_W-1:0] secondary;
	} execOp_t;

	typedef struct packed {
		logic valid;
		logic [`VLIW_REG_ADDR_W-1:0] addr;
		logic [`VLIW_DATA_W-1:0] data;
		logic overflow;
		logic underflow;
	} writeback_t;

	// one whole line per write
	typedef struct packed {
		logic enable;
		logic [$clog2(`VLIW_CACHE_LINES)-1:0] lineAddr;
		logic [`VLIW_LINE_W-1:0] line;
	} icacheWrite_t;

endpackage

`default_nettype wire

// ==== include/vliwCore_defs.svh ====
`ifndef VLIW_CORE_DEFS_SVH
`define VLIW_CORE_DEFS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// register and operand width
`define VLIW_DATA_W 16
`define VLIW_REG_ADDR_W 5
`define VLIW_INSTR_W 32

// two instructions per bundle
`define VLIW_BUNDLE_W 64

//////////////////////////////////////////////////
// instruction cache geometry
//////////////////////////////////////////////////

// 32 bytes per line, four bundles
`define VLIW_LINE_W 256
`define VLIW_CACHE_LINES 256
`define VLIW_BUNDLE_BYTES 8

// HALT decode to last writeback
`define VLIW_DRAIN_CYCLES 3

`endif
